// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing
TOP       ?= tb_status_dump
RTL_TOP   ?= status_dump
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides pass or fail
run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== logic/dump_pkg.sv ====
package dump_pkg;

    localparam int STATUS_W   = 32;
    localparam int CHAR_W     = 8;
    localparam int N_FIELDS   = 9;
    localparam int CHAR_IDX_W = 2;    // Labels are at most 4 chars

    localparam logic [CHAR_W-1:0] CHAR_EQ = 8'h3D;
    localparam logic [CHAR_W-1:0] CHAR_CR = 8'h0D;
    localparam logic [CHAR_W-1:0] CHAR_LF = 8'h0A;

    typedef enum logic [7:0] {
        CMD_NONE        = 8'h00,
        CMD_RUN         = 8'h01,
        CMD_STEP        = 8'h02,
        CMD_READ_MEM    = 8'h44,
        CMD_DUMP_STATUS = 8'h50
    } dbg_cmd_e;

    // Report order
    typedef enum logic [3:0] {
        FIELD_NPC = 4'd0,
        FIELD_PC  = 4'd1,
        FIELD_IR  = 4'd2,
        FIELD_CTL = 4'd3,
        FIELD_A   = 4'd4,
        FIELD_B   = 4'd5,
        FIELD_IMM = 4'd6,
        FIELD_Y   = 4'd7,
        FIELD_MDR = 4'd8
    } dump_field_e;

    typedef enum logic {
        TX_CHAR = 1'b0,    // Character in data[7:0]
        TX_WORD = 1'b1     // Full data word
    } tx_kind_e;

    typedef struct packed {
        logic [STATUS_W-1:0] npc;
        logic [STATUS_W-1:0] pc;
        logic [STATUS_W-1:0] ir;
        logic [STATUS_W-1:0] ctl;
        logic [STATUS_W-1:0] a;
        logic [STATUS_W-1:0] b;
        logic [STATUS_W-1:0] imm;
        logic [STATUS_W-1:0] y;
        logic [STATUS_W-1:0] mdr;
    } dp_status_t;

    typedef struct packed {
        tx_kind_e            kind;
        logic [STATUS_W-1:0] data;
    } tx_item_t;

endpackage

// ==== logic/dump_sequencer.sv ====
`timescale 1ns/1ps

module dump_sequencer (
    input  logic                              clk,
    input  logic                              rstn,
    input  dump_pkg::dbg_cmd_e                sel_mode,
    input  dump_pkg::dp_status_t              status,
    input  logic [dump_pkg::CHAR_W-1:0]       label_char,
    input  logic                              label_last,
    input  logic                              item_load,
    input  logic                              busy,
    output dump_pkg::dump_field_e             field,
    output logic [dump_pkg::CHAR_IDX_W-1:0]   char_idx,
    output dump_pkg::tx_item_t                item,
    output logic                              item_valid,
    output logic                              abort,
    output logic                              done
);

    typedef enum logic [2:0] {
        IDLE,
        LABEL,
        WORD,
        EOL_CR,
        EOL_LF,
        DRAIN,
        DONE
    } phase_e;

    phase_e phase;
    logic [dump_pkg::STATUS_W-1:0] word;

    assign abort = (sel_mode != dump_pkg::CMD_DUMP_STATUS);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            phase    <= IDLE;
            field    <= dump_pkg::FIELD_NPC;
            char_idx <= '0;
        end else if (abort) begin
            phase    <= IDLE;    // Restart from the first label next time
            field    <= dump_pkg::FIELD_NPC;
            char_idx <= '0;
        end else begin
            case (phase)
                IDLE: begin
                    phase    <= LABEL;
                    field    <= dump_pkg::FIELD_NPC;
                    char_idx <= '0;
                end
                LABEL: begin
                    if (item_load) begin
                        if (label_last) begin
                            phase    <= WORD;
                            char_idx <= '0;
                        end else begin
                            char_idx <= char_idx + 1'b1;
                        end
                    end
                end
                WORD: begin
                    if (item_load) begin
                        if (field == dump_pkg::dump_field_e'(dump_pkg::N_FIELDS - 1)) begin
                            phase <= EOL_CR;
                        end else begin
                            phase <= LABEL;
                            field <= dump_pkg::dump_field_e'(field + 4'd1);
                        end
                    end
                end
                EOL_CR: if (item_load) phase <= EOL_LF;
                EOL_LF: if (item_load) phase <= DRAIN;
                DRAIN:  if (!busy) phase <= DONE;    // Line feed acknowledged
                default: phase <= phase;             // DONE holds until abort
            endcase
        end
    end

    always_comb begin
        case (field)
            dump_pkg::FIELD_NPC: word = status.npc;
            dump_pkg::FIELD_PC:  word = status.pc;
            dump_pkg::FIELD_IR:  word = status.ir;
            dump_pkg::FIELD_CTL: word = status.ctl;
            dump_pkg::FIELD_A:   word = status.a;
            dump_pkg::FIELD_B:   word = status.b;
            dump_pkg::FIELD_IMM: word = status.imm;
            dump_pkg::FIELD_Y:   word = status.y;
            dump_pkg::FIELD_MDR: word = status.mdr;
            default:             word = '0;
        endcase
    end

    always_comb begin
        item.kind = dump_pkg::TX_CHAR;
        item.data = '0;
        case (phase)
            LABEL:   item.data[dump_pkg::CHAR_W-1:0] = label_char;
            EOL_CR:  item.data[dump_pkg::CHAR_W-1:0] = dump_pkg::CHAR_CR;
            EOL_LF:  item.data[dump_pkg::CHAR_W-1:0] = dump_pkg::CHAR_LF;
            WORD: begin
                item.kind = dump_pkg::TX_WORD;
                item.data = word;
            end
            default: item.data = '0;
        endcase
    end

    assign item_valid = (phase == LABEL) || (phase == WORD) ||
                        (phase == EOL_CR) || (phase == EOL_LF);
    assign done = (phase == DONE);

    // Walk ends on the equals sign and nowhere else
    a_label_end: assert property (@(posedge clk) disable iff (!rstn)
        (phase == LABEL) |-> (label_last == (label_char == dump_pkg::CHAR_EQ)));

endmodule

// ==== logic/field_label_rom.sv ====
`timescale 1ns/1ps

module field_label_rom (
    input  dump_pkg::dump_field_e              field,
    input  logic [dump_pkg::CHAR_IDX_W-1:0]    char_idx,
    output logic [dump_pkg::CHAR_W-1:0]        label_char,
    output logic                               label_last
);

    logic [3*dump_pkg::CHAR_W-1:0] text;    // Letters, left aligned
    logic [dump_pkg::CHAR_IDX_W-1:0] n_letters;

    always_comb begin
        case (field)
            dump_pkg::FIELD_NPC: begin text = "NPC";          n_letters = 2'd3; end
            dump_pkg::FIELD_PC:  begin text = {"PC", 8'h00};  n_letters = 2'd2; end
            dump_pkg::FIELD_IR:  begin text = {"IR", 8'h00};  n_letters = 2'd2; end
            dump_pkg::FIELD_CTL: begin text = "CTL";          n_letters = 2'd3; end
            dump_pkg::FIELD_A:   begin text = {"A", 16'h0};   n_letters = 2'd1; end
            dump_pkg::FIELD_B:   begin text = {"B", 16'h0};   n_letters = 2'd1; end
            dump_pkg::FIELD_IMM: begin text = "IMM";          n_letters = 2'd3; end
            dump_pkg::FIELD_Y:   begin text = {"Y", 16'h0};   n_letters = 2'd1; end
            dump_pkg::FIELD_MDR: begin text = "MDR";          n_letters = 2'd3; end
            default:             begin text = '0;             n_letters = 2'd0; end
        endcase
    end

    always_comb begin
        if (char_idx < n_letters) begin
            label_last = 1'b0;
            case (char_idx)
                2'd0:    label_char = text[23:16];
                2'd1:    label_char = text[15:8];
                default: label_char = text[7:0];
            endcase
        end else begin
            // Equals sign closes every label, also past the end
            label_char = dump_pkg::CHAR_EQ;
            label_last = 1'b1;
        end
    end

endmodule

// ==== logic/status_dump.sv ====
`timescale 1ns/1ps

module status_dump (
    input  logic                   clk,
    input  logic                   rstn,
    input  dump_pkg::dbg_cmd_e     sel_mode,
    input  dump_pkg::dp_status_t   status,
    input  logic                   ack_tx,
    output logic                   req_tx,
    output dump_pkg::tx_item_t     item_tx,
    output logic                   done
);

    dump_pkg::dump_field_e             field;
    logic [dump_pkg::CHAR_IDX_W-1:0]   char_idx;
    logic [dump_pkg::CHAR_W-1:0]       label_char;
    logic                              label_last;
    dump_pkg::tx_item_t                item;
    logic                              item_valid;
    logic                              item_load;
    logic                              abort;
    logic                              busy;

    dump_sequencer seq0 (
        .clk        (clk),
        .rstn       (rstn),
        .sel_mode   (sel_mode),
        .status     (status),
        .label_char (label_char),
        .label_last (label_last),
        .item_load  (item_load),
        .busy       (busy),
        .field      (field),
        .char_idx   (char_idx),
        .item       (item),
        .item_valid (item_valid),
        .abort      (abort),
        .done       (done)
    );

    field_label_rom rom0 (
        .field      (field),
        .char_idx   (char_idx),
        .label_char (label_char),
        .label_last (label_last)
    );

    tx_port port0 (
        .clk        (clk),
        .rstn       (rstn),
        .item       (item),
        .item_valid (item_valid),
        .abort      (abort),
        .ack_tx     (ack_tx),
        .item_load  (item_load),
        .busy       (busy),
        .req_tx     (req_tx),
        .item_tx    (item_tx)
    );

endmodule

// ==== logic/tx_port.sv ====
`timescale 1ns/1ps

module tx_port (
    input  logic                 clk,
    input  logic                 rstn,
    input  dump_pkg::tx_item_t   item,
    input  logic                 item_valid,
    input  logic                 abort,
    input  logic                 ack_tx,
    output logic                 item_load,
    output logic                 busy,
    output logic                 req_tx,
    output dump_pkg::tx_item_t   item_tx
);

    typedef enum logic {
        EMPTY,
        FULL
    } port_state_e;

    port_state_e state;

    assign item_load = item_valid && (state == EMPTY) && !abort;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state   <= EMPTY;
            item_tx <= '0;
        end else if (abort) begin
            state <= EMPTY;    // Ack in this cycle is ignored
        end else if (item_load) begin
            state   <= FULL;
            item_tx <= item;
        end else if (state == FULL && ack_tx) begin
            state <= EMPTY;    // Gives the one-cycle low on req_tx
        end
    end

    assign req_tx = (state == FULL);

    // Still holding after this edge
    assign busy = (state == FULL) && !ack_tx;

    a_item_hold: assert property (@(posedge clk) disable iff (!rstn)
        (req_tx && !ack_tx && !abort) |=> (req_tx && $stable(item_tx)));

    // Transmitter must not acknowledge without a request
    a_ack_needs_req: assert property (@(posedge clk) disable iff (!rstn)
        ack_tx |-> req_tx);

endmodule

// ==== testbench/tb_status_dump.sv ====
`timescale 1ns/1ps

module tb_status_dump;

    localparam int N_ITEMS    = 39;
    localparam int CLK_PERIOD = 20;
    localparam int REQ_WAIT   = 20;
    // 5 tests, 2 reports each, 39 items, at most 8 cycles per item
    localparam int WATCHDOG_NS = 5 * 2 * N_ITEMS * 8 * CLK_PERIOD + 20000;

    logic                 clk;
    logic                 rstn;
    dump_pkg::dbg_cmd_e   sel_mode;
    dump_pkg::dp_status_t status;
    logic                 ack_tx;
    logic                 req_tx;
    dump_pkg::tx_item_t   item_tx;
    logic                 done;

    dump_pkg::tx_item_t   expected [N_ITEMS];
    string                labels [dump_pkg::N_FIELDS];
    int                   errors;
    integer               seed;

    status_dump dut0 (
        .clk      (clk),
        .rstn     (rstn),
        .sel_mode (sel_mode),
        .status   (status),
        .ack_tx   (ack_tx),
        .req_tx   (req_tx),
        .item_tx  (item_tx),
        .done     (done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired at %0t, the report never completed", $time);
        $display("TESTS FAILED");
        $finish;
    end

    // Labels, then word, per field; CR LF at the end
    function automatic void build_expected(input dump_pkg::dp_status_t s);
        logic [dump_pkg::N_FIELDS*dump_pkg::STATUS_W-1:0] flat;
        int n;
        flat = s;
        n = 0;
        for (int f = 0; f < dump_pkg::N_FIELDS; f++) begin
            for (int i = 0; i < labels[f].len(); i++) begin
                expected[n] = {dump_pkg::TX_CHAR, 24'h0, labels[f][i]};
                n++;
            end
            expected[n] = {dump_pkg::TX_WORD,
                           flat[(dump_pkg::N_FIELDS-1-f)*dump_pkg::STATUS_W +: dump_pkg::STATUS_W]};
            n++;
        end
        expected[n]     = {dump_pkg::TX_CHAR, 24'h0, 8'h0D};
        expected[n + 1] = {dump_pkg::TX_CHAR, 24'h0, 8'h0A};
    endfunction

    task automatic check_item(input string name, input logic [32:0] got, input logic [32:0] want);
        assert (got === want) else begin
            errors++;
            $display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, got, want);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic want);
        assert (got === want) else begin
            errors++;
            $display("CHECK FAILED at %0t: %s = %b, expected %b", $time, name, got, want);
        end
    endtask

    task automatic wait_request(output bit seen);
        int waited;
        waited = 0;
        while (!req_tx && waited < REQ_WAIT) begin
            @(negedge clk);
            waited++;
        end
        seen = req_tx;
        assert (seen) else begin
            errors++;
            $display("At %0t the DUT raised no transmit request within %0d cycles",
                     $time, REQ_WAIT);
        end
    endtask

    // Acknowledging transmitter that compares every transferred item
    task automatic accept_items(input int first, input int count, input bit random_delay);
        int delay;
        bit seen;
        dump_pkg::tx_item_t held;
        for (int k = first; k < first + count; k++) begin
            wait_request(seen);
            if (!seen) return;
            held = item_tx;
            delay = random_delay ? $unsigned($random(seed)) % 6 : 0;
            repeat (delay) begin
                @(negedge clk);
                check_bit("req_tx", req_tx, 1'b1);
                check_item("item_tx", item_tx, held);    // Held under back-pressure
            end
            check_item("item_tx", item_tx, expected[k]);
            check_bit("done", done, 1'b0);
            ack_tx = 1'b1;
            @(negedge clk);
            ack_tx = 1'b0;
            check_bit("req_tx", req_tx, 1'b0);    // Gap cycle after a transfer
        end
    endtask

    task automatic start_report(input dump_pkg::dp_status_t s);
        status = s;
        build_expected(s);
        sel_mode = dump_pkg::CMD_DUMP_STATUS;
        @(negedge clk);
        check_bit("req_tx", req_tx, 1'b0);
        @(negedge clk);
        check_bit("req_tx", req_tx, 1'b1);    // Two cycles after the command
    endtask

    task automatic leave_command(input int cycles);
        sel_mode = dump_pkg::CMD_NONE;
        repeat (cycles) begin
            @(negedge clk);
            check_bit("req_tx", req_tx, 1'b0);
            check_bit("done", done, 1'b0);
        end
    endtask

    task automatic check_quiet_done(input int cycles);
        repeat (cycles) begin
            check_bit("done", done, 1'b1);
            check_bit("req_tx", req_tx, 1'b0);
            @(negedge clk);
        end
    endtask

    task automatic test_reset_state();
        rstn = 1'b0;
        repeat (8) begin
            @(negedge clk);
            check_bit("req_tx", req_tx, 1'b0);
            check_bit("done", done, 1'b0);
            check_item("item_tx", item_tx, '0);
        end
        rstn = 1'b1;
        leave_command(10);
    endtask

    task automatic test_full_report(input dump_pkg::dp_status_t s);
        start_report(s);
        accept_items(0, N_ITEMS, 1'b0);
        check_quiet_done(20);
    endtask

    task automatic test_back_pressure(input dump_pkg::dp_status_t s);
        leave_command(2);
        start_report(s);
        accept_items(0, N_ITEMS, 1'b1);
        check_quiet_done(5);
    endtask

    task automatic test_abort(input dump_pkg::dp_status_t s);
        bit seen;
        leave_command(2);
        start_report(s);
        accept_items(0, 10, 1'b1);
        wait_request(seen);    // Abort while an item is pending
        leave_command(5);
        start_report(s);
        accept_items(0, N_ITEMS, 1'b1);
        check_quiet_done(5);
    endtask

    task automatic test_one_report(input dump_pkg::dp_status_t s);
        check_quiet_done(20);
        leave_command(3);
        start_report(s);
        accept_items(0, N_ITEMS, 1'b0);
        check_quiet_done(10);
    endtask

    initial begin
        errors   = 0;
        seed     = 77;
        rstn     = 1'b0;
        ack_tx   = 1'b0;
        sel_mode = dump_pkg::CMD_NONE;
        status   = '0;
        labels   = '{"NPC=", "PC=", "IR=", "CTL=", "A=", "B=", "IMM=", "Y=", "MDR="};

        test_reset_state();
        test_full_report({32'h0000_1004, 32'h0000_1000, 32'h8C22_0010, 32'h0000_A5C3,
                          32'h1234_5678, 32'hFFFF_FFF0, 32'h0000_0010, 32'h1234_5688,
                          32'hDEAD_BEEF});
        test_back_pressure({32'h0000_1004, 32'h0000_1000, 32'h8C22_0010, 32'h0000_A5C3,
                            32'h1234_5678, 32'hFFFF_FFF0, 32'h0000_0010, 32'h1234_5688,
                            32'hDEAD_BEEF});
        test_abort({32'h0040_0020, 32'h0040_001C, 32'h0043_2020, 32'h0000_3C01,
                    32'h0000_0007, 32'h0000_0003, 32'h0000_0000, 32'h0000_000A,
                    32'h0BAD_F00D});
        test_one_report({32'hCAFE_0004, 32'hCAFE_0000, 32'hAC85_FFFC, 32'h0000_5A5A,
                         32'h8000_0000, 32'h7FFF_FFFF, 32'hFFFF_FFFC, 32'hFFFF_FFFF,
                         32'h0102_0304});

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
logic/dump_pkg.sv
logic/field_label_rom.sv
logic/dump_sequencer.sv
logic/tx_port.sv
logic/status_dump.sv
testbench/tb_status_dump.sv
